//--- filelist.f
+incdir+source
+incdir+testbench
source/epu_types_pkg.sv
source/epu_fsm_pkg.sv
source/epu_ifs.sv
source/epu_layer_decode.sv
source/epu_loop_counters.sv
source/epu_sequencer.sv
source/epu_control.sv
testbench/epu_tb.sv

//--- source/epu_control.sv
`timescale 1ns/100ps
`default_nettype none

module epu_control (
	input  wire                        i_clk,
	input  wire                        rst,
	input  wire                        i_start,
	input  wire                        i_window_done,
	input  wire                        i_column_done,
	input  wire                        i_vector_done,
	input  wire                        i_weight_done,
	input  wire                        i_save_done,
	output logic                       o_read_window,
	output logic                       o_read_column,
	output logic                       o_read_vector,
	output logic                       o_read_weight,
	output logic                       o_save_rows,
	output logic                       o_cal_start,
	output epu_types_pkg::chan_t       o_ifchannel,
	output epu_types_pkg::chan_t       o_ofchannel,
	output epu_types_pkg::layer_idx_t  o_layer,
	output epu_types_pkg::layer_mask_t o_layer_done,
	output logic                       o_epu_done
);

	layer_cfg_if cfg ();
	loop_if      loop ();

	logic layer_end;

	epu_layer_decode u_decode (
		.clk          (i_clk),
		.rst          (rst),
		.i_layer_end  (layer_end),
		.cfg          (cfg.decode),
		.o_layer      (o_layer),
		.o_layer_done (o_layer_done),
		.o_epu_done   (o_epu_done)
	);

	epu_sequencer u_sequencer (
		.clk           (i_clk),
		.rst           (rst),
		.i_start       (i_start),
		.i_window_done (i_window_done),
		.i_column_done (i_column_done),
		.i_vector_done (i_vector_done),
		.i_weight_done (i_weight_done),
		.i_save_done   (i_save_done),
		.cfg           (cfg.user),
		.loop          (loop.sequencer),
		.o_layer_end   (layer_end),
		.o_read_window (o_read_window),
		.o_read_column (o_read_column),
		.o_read_vector (o_read_vector),
		.o_read_weight (o_read_weight),
		.o_save_rows   (o_save_rows),
		.o_cal_start   (o_cal_start)
	);

	epu_loop_counters u_counters (
		.clk         (i_clk),
		.rst         (rst),
		.cfg         (cfg.user),
		.loop        (loop.counters),
		.o_ifchannel (o_ifchannel),
		.o_ofchannel (o_ofchannel)
	);

endmodule

`default_nettype wire

//--- source/epu_fsm_pkg.sv
`default_nettype none

package epu_fsm_pkg;

	typedef enum logic {
		KIND_CONV,
		KIND_FC
	} layer_kind_e;

	// request states are named after the request they hold
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_READ_WINDOW,
		ST_READ_WEIGHT,
		ST_CALC,
		ST_READ_COLUMN,
		ST_SAVE,
		ST_READ_VECTOR,
		ST_LAYER_END
	} seq_state_e;

endpackage

`default_nettype wire

//--- source/epu_ifs.sv
`timescale 1ns/100ps
`default_nettype none

// geometry of the current layer, stable for the whole layer
interface layer_cfg_if;
	import epu_types_pkg::*;
	import epu_fsm_pkg::*;

	layer_kind_e kind;
	layer_kind_e next_kind;
	col_t        width;
	pair_t       pairs;
	chan_t       ifch;
	chan_t       ofch;
	logic        last_layer;

	modport decode (output kind, next_kind, width, pairs, ifch, ofch, last_layer);
	modport user (input kind, next_kind, width, pairs, ifch, ofch, last_layer);
endinterface

// advance strobes out of the sequencer, boundary flags back from the counters
interface loop_if;
	logic calc_active;
	logic adv_pixel;
	logic adv_row;
	logic adv_ifch;
	logic adv_pair;
	logic adv_ofch;
	logic layer_start;
	logic last_cycle;
	logic last_pixel;
	logic second_row;
	logic last_ifch;
	logic last_pair;
	logic last_ofch;

	modport sequencer (
		output calc_active, adv_pixel, adv_row, adv_ifch, adv_pair, adv_ofch, layer_start,
		input  last_cycle, last_pixel, second_row, last_ifch, last_pair, last_ofch
	);
	modport counters (
		input  calc_active, adv_pixel, adv_row, adv_ifch, adv_pair, adv_ofch, layer_start,
		output last_cycle, last_pixel, second_row, last_ifch, last_pair, last_ofch
	);
endinterface

`default_nettype wire

//--- source/epu_layer_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "epu_params.svh"

module epu_layer_decode (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        i_layer_end,
	layer_cfg_if.decode                cfg,
	output epu_types_pkg::layer_idx_t  o_layer,
	output epu_types_pkg::layer_mask_t o_layer_done,
	output logic                       o_epu_done
);
	import epu_types_pkg::*;
	import epu_fsm_pkg::*;

	localparam layer_idx_t LAST_LAYER = layer_idx_t'(`EPU_NUM_LAYERS - 1);

	localparam col_t WIDTH_LUT [`EPU_NUM_LAYERS] = '{`EPU_L0_WIDTH, `EPU_L1_WIDTH,
		`EPU_L2_WIDTH, `EPU_L3_WIDTH, `EPU_L4_WIDTH, `EPU_L5_WIDTH};
	localparam pair_t PAIRS_LUT [`EPU_NUM_LAYERS] = '{`EPU_L0_PAIRS, `EPU_L1_PAIRS,
		`EPU_L2_PAIRS, `EPU_L3_PAIRS, `EPU_L4_PAIRS, `EPU_L5_PAIRS};
	localparam chan_t IFCH_LUT [`EPU_NUM_LAYERS] = '{`EPU_L0_IFCH, `EPU_L1_IFCH,
		`EPU_L2_IFCH, `EPU_L3_IFCH, `EPU_L4_IFCH, `EPU_L5_IFCH};
	localparam chan_t OFCH_LUT [`EPU_NUM_LAYERS] = '{`EPU_L0_OFCH, `EPU_L1_OFCH,
		`EPU_L2_OFCH, `EPU_L3_OFCH, `EPU_L4_OFCH, `EPU_L5_OFCH};

	layer_idx_t layer_q;
	layer_idx_t next_idx;

	function automatic layer_kind_e kind_of(input layer_idx_t idx);
		kind_of = (idx < `EPU_NUM_CONV) ? KIND_CONV : KIND_FC;
	endfunction

	// wraps back to the first layer after a full run
	assign next_idx = (layer_q == LAST_LAYER) ? '0 : layer_idx_t'(layer_q + 3'd1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			layer_q <= '0;
			o_layer_done <= '0;
			o_epu_done <= 1'b0;
		end else begin
			o_layer_done <= '0;
			o_epu_done <= 1'b0;
			if (i_layer_end) begin
				layer_q <= next_idx;
				o_layer_done[layer_q] <= 1'b1;
				o_epu_done <= (layer_q == LAST_LAYER);
			end
		end
	end

	assign o_layer = layer_q;

	assign cfg.kind = kind_of(layer_q);
	// lets the sequencer pick the first request of the next layer
	assign cfg.next_kind = kind_of(next_idx);
	assign cfg.last_layer = (layer_q == LAST_LAYER);
	assign cfg.width = WIDTH_LUT[layer_q];
	assign cfg.pairs = PAIRS_LUT[layer_q];
	assign cfg.ifch = IFCH_LUT[layer_q];
	assign cfg.ofch = OFCH_LUT[layer_q];

	a_layer_range: assert property (@(posedge clk) disable iff (rst)
		layer_q < `EPU_NUM_LAYERS);

endmodule

`default_nettype wire

//--- source/epu_loop_counters.sv
`timescale 1ns/100ps
`default_nettype none

`include "epu_params.svh"

module epu_loop_counters (
	input  wire                  clk,
	input  wire                  rst,
	layer_cfg_if.user            cfg,
	loop_if.counters             loop,
	output epu_types_pkg::chan_t o_ifchannel,
	output epu_types_pkg::chan_t o_ofchannel
);
	import epu_types_pkg::*;

	pixel_cyc_t cyc_q;
	col_t       col_q;
	logic       row_q;
	chan_t      ifch_q;
	pair_t      pair_q;
	chan_t      ofch_q;
	logic       clr_col;
	logic       clr_row;
	logic       clr_ifch;
	logic       clr_pair;

	// an advance clears every loop nested inside it
	assign clr_pair = loop.adv_ofch | loop.layer_start;
	assign clr_ifch = loop.adv_pair | clr_pair;
	assign clr_row = loop.adv_ifch | clr_ifch;
	assign clr_col = loop.adv_row | clr_row;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			cyc_q <= '0;
		else if (!loop.calc_active || loop.last_cycle)
			cyc_q <= '0;
		else
			cyc_q <= cyc_q + 2'd1;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			col_q <= '0;
			row_q <= 1'b0;
			ifch_q <= '0;
			pair_q <= '0;
			ofch_q <= '0;
		end else begin
			if (clr_col)
				col_q <= '0;
			else if (loop.adv_pixel)
				col_q <= col_q + 7'd1;
			if (clr_row)
				row_q <= 1'b0;
			else if (loop.adv_row)
				row_q <= 1'b1;
			if (clr_ifch)
				ifch_q <= '0;
			else if (loop.adv_ifch)
				ifch_q <= ifch_q + 5'd1;
			if (clr_pair)
				pair_q <= '0;
			else if (loop.adv_pair)
				pair_q <= pair_q + 6'd1;
			if (loop.layer_start)
				ofch_q <= '0;
			else if (loop.adv_ofch)
				ofch_q <= ofch_q + 5'd1;
		end
	end

	assign loop.last_cycle = (cyc_q == pixel_cyc_t'(`EPU_PIXEL_CYCLES - 1));
	assign loop.last_pixel = (col_q == col_t'(cfg.width - 7'd1));
	assign loop.second_row = row_q;
	assign loop.last_ifch = (ifch_q == chan_t'(cfg.ifch - 5'd1));
	assign loop.last_pair = (pair_q == pair_t'(cfg.pairs - 6'd1));
	assign loop.last_ofch = (ofch_q == chan_t'(cfg.ofch - 5'd1));

	assign o_ifchannel = ifch_q;
	assign o_ofchannel = ofch_q;

	// sequencer never advances past the last channel of the current layer
	a_chan_range: assert property (@(posedge clk) disable iff (rst)
		(ifch_q < cfg.ifch) && (ofch_q < cfg.ofch));

endmodule

`default_nettype wire

//--- source/epu_params.svh
`ifndef EPU_PARAMS_SVH
`define EPU_PARAMS_SVH

// compute cycles per output value
`define EPU_PIXEL_CYCLES 3
`define EPU_NUM_LAYERS   6
// conv layers come first, fc layers after them
`define EPU_NUM_CONV     4

`define EPU_L0_WIDTH 96
`define EPU_L0_PAIRS 48
`define EPU_L0_IFCH  1
`define EPU_L0_OFCH  4

`define EPU_L1_WIDTH 44
`define EPU_L1_PAIRS 22
`define EPU_L1_IFCH  4
`define EPU_L1_OFCH  8

`define EPU_L2_WIDTH 18
`define EPU_L2_PAIRS 9
`define EPU_L2_IFCH  8
`define EPU_L2_OFCH  8

`define EPU_L3_WIDTH 4
`define EPU_L3_PAIRS 2
`define EPU_L3_IFCH  8
`define EPU_L3_OFCH  8

// fc layers only loop over outputs
`define EPU_L4_WIDTH 1
`define EPU_L4_PAIRS 1
`define EPU_L4_IFCH  1
`define EPU_L4_OFCH  16

`define EPU_L5_WIDTH 1
`define EPU_L5_PAIRS 1
`define EPU_L5_IFCH  1
`define EPU_L5_OFCH  5

`endif

//--- source/epu_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "epu_params.svh"

module epu_sequencer (
	input  wire       clk,
	input  wire       rst,
	input  wire       i_start,
	input  wire       i_window_done,
	input  wire       i_column_done,
	input  wire       i_vector_done,
	input  wire       i_weight_done,
	input  wire       i_save_done,
	layer_cfg_if.user cfg,
	loop_if.sequencer loop,
	output logic      o_layer_end,
	output logic      o_read_window,
	output logic      o_read_column,
	output logic      o_read_vector,
	output logic      o_read_weight,
	output logic      o_save_rows,
	output logic      o_cal_start
);
	import epu_fsm_pkg::*;

	seq_state_e state_q;
	seq_state_e state_d;

	// first request of a layer
	function automatic seq_state_e entry_state(input layer_kind_e kind);
		entry_state = (kind == KIND_CONV) ? ST_READ_WINDOW : ST_READ_VECTOR;
	endfunction

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d = state_q;
		loop.adv_pixel = 1'b0;
		loop.adv_row = 1'b0;
		loop.adv_ifch = 1'b0;
		loop.adv_pair = 1'b0;
		loop.adv_ofch = 1'b0;
		case (state_q)
			ST_IDLE: begin
				if (i_start)
					state_d = entry_state(cfg.kind);
			end
			ST_READ_WINDOW: begin
				// second row of a pair reuses the weight already loaded
				if (i_window_done)
					state_d = loop.second_row ? ST_CALC : ST_READ_WEIGHT;
			end
			ST_READ_WEIGHT: begin
				if (i_weight_done)
					state_d = ST_CALC;
			end
			ST_READ_COLUMN: begin
				if (i_column_done)
					state_d = ST_CALC;
			end
			ST_READ_VECTOR: begin
				if (i_vector_done)
					state_d = ST_READ_WEIGHT;
			end
			ST_CALC: begin
				if (loop.last_cycle) begin
					if (cfg.kind == KIND_FC) begin
						if (loop.last_ofch) begin
							state_d = ST_LAYER_END;
						end else begin
							loop.adv_ofch = 1'b1;
							state_d = ST_READ_WEIGHT;
						end
					end else if (!loop.last_pixel) begin
						loop.adv_pixel = 1'b1;
						state_d = ST_READ_COLUMN;
					end else if (!loop.second_row) begin
						loop.adv_row = 1'b1;
						state_d = ST_READ_WINDOW;
					end else if (!loop.last_ifch) begin
						loop.adv_ifch = 1'b1;
						state_d = ST_READ_WINDOW;
					end else begin
						state_d = ST_SAVE;
					end
				end
			end
			ST_SAVE: begin
				if (i_save_done) begin
					if (!loop.last_pair) begin
						loop.adv_pair = 1'b1;
						state_d = ST_READ_WINDOW;
					end else if (!loop.last_ofch) begin
						loop.adv_ofch = 1'b1;
						state_d = ST_READ_WINDOW;
					end else begin
						state_d = ST_LAYER_END;
					end
				end
			end
			ST_LAYER_END: begin
				state_d = cfg.last_layer ? ST_IDLE : entry_state(cfg.next_kind);
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	assign o_read_window = (state_q == ST_READ_WINDOW);
	assign o_read_column = (state_q == ST_READ_COLUMN);
	assign o_read_vector = (state_q == ST_READ_VECTOR);
	assign o_read_weight = (state_q == ST_READ_WEIGHT);
	assign o_save_rows = (state_q == ST_SAVE);
	assign o_cal_start = (state_q == ST_CALC);
	assign o_layer_end = (state_q == ST_LAYER_END);

	assign loop.calc_active = (state_q == ST_CALC);
	// counters restart on the same edge the layer register advances
	assign loop.layer_start = (state_q == ST_LAYER_END);

	a_one_active: assert property (@(posedge clk) disable iff (rst)
		$onehot0({o_read_window, o_read_column, o_read_vector, o_read_weight, o_save_rows,
			o_cal_start}));

	// compute length is set by the pixel cycle counter
	a_calc_length: assert property (@(posedge clk) disable iff (rst)
		$rose(o_cal_start) |-> o_cal_start [*`EPU_PIXEL_CYCLES] ##1 !o_cal_start);

endmodule

`default_nettype wire

//--- source/epu_types_pkg.sv
`default_nettype none

package epu_types_pkg;

	// cycle within one compute
	typedef logic [1:0] pixel_cyc_t;

	// pixel within a row, also holds the row width
	typedef logic [6:0] col_t;

	typedef logic [5:0] pair_t;

	// channel index or channel count
	typedef logic [4:0] chan_t;

	typedef logic [2:0] layer_idx_t;

	// one bit per layer
	typedef logic [5:0] layer_mask_t;

endpackage

`default_nettype wire

//--- testbench/epu_tb_tasks.svh
`ifndef EPU_TB_TASKS_SVH
`define EPU_TB_TASKS_SVH

task automatic check_count(input string name, input int got, input int exp);
	if (got !== exp) begin
		value_errs++;
		$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		value_errs++;
		$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
	end
endtask

task automatic check_chan(input string name, input chan_t got, input chan_t exp);
	if (got !== exp) begin
		value_errs++;
		$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
	end
endtask

task automatic check_layer(input string name, input layer_idx_t got, input layer_idx_t exp);
	if (got !== exp) begin
		value_errs++;
		$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
	end
endtask

task automatic check_mask(input string name, input layer_mask_t got, input layer_mask_t exp);
	if (got !== exp) begin
		value_errs++;
		$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
	end
endtask

// kinds are window, column, vector, weight, save
function automatic int expected_hs(input int kind, input int l);
	int kpc;
	kpc = geo_k[l] * geo_p[l] * geo_c[l];
	if (l < `EPU_NUM_CONV) begin
		case (kind)
			0: return 2 * kpc;
			1: return 2 * kpc * (geo_w[l] - 1);
			3: return kpc;
			4: return geo_k[l] * geo_p[l];
			default: return 0;
		endcase
	end
	return (kind == 2) ? 1 : (kind == 3) ? geo_k[l] : 0;
endfunction

function automatic int expected_calc(input int l);
	if (l < `EPU_NUM_CONV)
		return 2 * geo_k[l] * geo_p[l] * geo_c[l] * geo_w[l];
	return geo_k[l];
endfunction

function automatic int timeout_cycles();
	int total;
	total = 0;
	for (int l = 0; l < NL; l++) begin
		for (int k = 0; k < 5; k++)
			total += expected_hs(k, l);
		total += expected_calc(l) + 1;
	end
	// two runs, worst case delay plus one compute per handshake
	return 2 * total * (MAX_DELAY + 1 + `EPU_PIXEL_CYCLES) + 1000;
endfunction

// weight reads walk ofch, then pair, then ifch innermost
task automatic check_weight_channels();
	check_chan("o_ifchannel", o_ifchannel, chan_t'(exp_if));
	check_chan("o_ofchannel", o_ofchannel, chan_t'(exp_of));
	weight_checks++;
	exp_if++;
	if (exp_if == geo_c[o_layer]) begin
		exp_if = 0;
		exp_pair++;
		if (exp_pair == geo_p[o_layer]) begin
			exp_pair = 0;
			exp_of++;
		end
	end
endtask

task automatic track_compute();
	if (o_cal_start) begin
		if (burst_len == 0)
			calc_cnt[o_layer]++;
		burst_len++;
	end else if (burst_len > 0) begin
		check_count("o_cal_start burst length", burst_len, `EPU_PIXEL_CYCLES);
		burst_len = 0;
	end
endtask

task automatic track_layer_done();
	if (o_layer_done != '0) begin
		check_mask("o_layer_done", o_layer_done, layer_mask_t'(1 << next_done));
		check_bit("o_epu_done", o_epu_done, next_done == NL - 1);
		check_layer("o_layer", o_layer, layer_idx_t'((next_done + 1) % NL));
		for (int l = 0; l < NL; l++)
			if (o_layer_done[l])
				done_cnt[l]++;
		next_done = (next_done + 1) % NL;
		exp_if = 0;
		exp_pair = 0;
		exp_of = 0;
	end else if (o_epu_done) begin
		proto_errs++;
		$display("at %0t o_epu_done pulsed without the last layer done", $time);
	end
	if (o_epu_done)
		epu_done_cnt++;
endtask

task automatic run_network(input bit random_delay);
	for (int l = 0; l < NL; l++) begin
		for (int k = 0; k < 5; k++)
			hs_cnt[k][l] = 0;
		calc_cnt[l] = 0;
		done_cnt[l] = 0;
	end
	epu_done_cnt = 0;
	weight_checks = 0;
	next_done = 0;
	rand_delay = random_delay;
	i_start = 1'b1;
	@(negedge clk);
	i_start = 1'b0;
	while (!o_epu_done)
		@(negedge clk);
	repeat (5) @(negedge clk);
	check_layer("o_layer after run", o_layer, '0);
	check_count("o_epu_done pulses", epu_done_cnt, 1);
endtask

task automatic check_run_counts();
	for (int l = 0; l < NL; l++) begin
		for (int k = 0; k < 5; k++)
			check_count($sformatf("layer %0d %s handshakes", l, kind_name[k]),
				hs_cnt[k][l], expected_hs(k, l));
		check_count($sformatf("layer %0d computes", l), calc_cnt[l], expected_calc(l));
	end
endtask

task automatic test_reset_idle();
	repeat (20) begin
		@(negedge clk);
		check_bit("o_read_window", o_read_window, 1'b0);
		check_bit("o_read_column", o_read_column, 1'b0);
		check_bit("o_read_vector", o_read_vector, 1'b0);
		check_bit("o_read_weight", o_read_weight, 1'b0);
		check_bit("o_save_rows", o_save_rows, 1'b0);
		check_bit("o_cal_start", o_cal_start, 1'b0);
		check_bit("o_epu_done", o_epu_done, 1'b0);
		check_mask("o_layer_done", o_layer_done, '0);
		check_layer("o_layer", o_layer, '0);
	end
endtask

task automatic test_full_run();
	run_network(1'b0);
	check_run_counts();
endtask

task automatic test_layer_order();
	for (int l = 0; l < NL; l++)
		check_count($sformatf("layer %0d done pulses", l), done_cnt[l], 1);
endtask

task automatic test_channels();
	int total;
	total = 0;
	for (int l = 0; l < NL; l++)
		total += expected_hs(3, l);
	check_count("checked weight reads", weight_checks, total);
endtask

task automatic test_backpressure();
	run_network(1'b1);
	check_run_counts();
	test_layer_order();
	test_channels();
endtask

`endif

//--- testbench/epu_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "epu_params.svh"

module epu_tb;
	import epu_types_pkg::*;

	localparam int MAX_DELAY = 7;
	localparam int NL = `EPU_NUM_LAYERS;

	logic        clk;
	logic        rst;
	logic        i_start;
	logic        i_window_done;
	logic        i_column_done;
	logic        i_vector_done;
	logic        i_weight_done;
	logic        i_save_done;
	logic        o_read_window;
	logic        o_read_column;
	logic        o_read_vector;
	logic        o_read_weight;
	logic        o_save_rows;
	logic        o_cal_start;
	chan_t       o_ifchannel;
	chan_t       o_ofchannel;
	layer_idx_t  o_layer;
	layer_mask_t o_layer_done;
	logic        o_epu_done;

	// layer geometry
	int geo_w [NL] = '{`EPU_L0_WIDTH, `EPU_L1_WIDTH, `EPU_L2_WIDTH, `EPU_L3_WIDTH,
		`EPU_L4_WIDTH, `EPU_L5_WIDTH};
	int geo_p [NL] = '{`EPU_L0_PAIRS, `EPU_L1_PAIRS, `EPU_L2_PAIRS, `EPU_L3_PAIRS,
		`EPU_L4_PAIRS, `EPU_L5_PAIRS};
	int geo_c [NL] = '{`EPU_L0_IFCH, `EPU_L1_IFCH, `EPU_L2_IFCH, `EPU_L3_IFCH,
		`EPU_L4_IFCH, `EPU_L5_IFCH};
	int geo_k [NL] = '{`EPU_L0_OFCH, `EPU_L1_OFCH, `EPU_L2_OFCH, `EPU_L3_OFCH,
		`EPU_L4_OFCH, `EPU_L5_OFCH};
	string kind_name [5] = '{"window", "column", "vector", "weight", "save"};

	int hs_cnt [5][NL];
	int calc_cnt [NL];
	int done_cnt [NL];
	int epu_done_cnt;
	int weight_checks;
	int value_errs = 0;
	int proto_errs = 0;
	int cycles = 0;
	int cycle_limit = 0;
	bit rand_delay = 1'b0;
	logic [31:0] rng = 32'd95863;
	logic [4:0] prev_req = '0;
	logic [4:0] prev_done = '0;
	bit pending = 1'b0;
	int wait_left = 0;
	int burst_len = 0;
	int next_done = 0;
	int exp_if = 0;
	int exp_pair = 0;
	int exp_of = 0;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	`include "epu_tb_tasks.svh"

	epu_control dut (
		.i_clk         (clk),
		.rst           (rst),
		.i_start       (i_start),
		.i_window_done (i_window_done),
		.i_column_done (i_column_done),
		.i_vector_done (i_vector_done),
		.i_weight_done (i_weight_done),
		.i_save_done   (i_save_done),
		.o_read_window (o_read_window),
		.o_read_column (o_read_column),
		.o_read_vector (o_read_vector),
		.o_read_weight (o_read_weight),
		.o_save_rows   (o_save_rows),
		.o_cal_start   (o_cal_start),
		.o_ifchannel   (o_ifchannel),
		.o_ofchannel   (o_ofchannel),
		.o_layer       (o_layer),
		.o_layer_done  (o_layer_done),
		.o_epu_done    (o_epu_done)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
			$display("Some tests failed");
			$finish;
		end
	end

	// responder and handshake monitors
	always @(negedge clk) begin
		logic [4:0] req;
		logic [4:0] done;
		req = {o_save_rows, o_read_weight, o_read_vector, o_read_column, o_read_window};
		done = '0;
		if (!rst) begin
			if ((prev_req & ~prev_done & ~req) != '0) begin
				proto_errs++;
				$display("at %0t a request dropped before its done arrived", $time);
			end
			if (!$onehot0({req, o_cal_start})) begin
				proto_errs++;
				$display("at %0t more than one request or compute is active", $time);
			end
			if (req == '0) begin
				pending = 1'b0;
			end else begin
				if (!pending) begin
					pending = 1'b1;
					rng = xorshift(rng);
					wait_left = rand_delay ? int'(rng % (MAX_DELAY + 1)) : 0;
				end
				if (wait_left == 0) begin
					done = req;
					pending = 1'b0;
					for (int k = 0; k < 5; k++)
						if (req[k])
							hs_cnt[k][o_layer]++;
					if (req[3])
						check_weight_channels();
				end else begin
					wait_left--;
				end
			end
			track_compute();
			track_layer_done();
		end
		prev_req = req;
		prev_done = done;
		{i_save_done, i_weight_done, i_vector_done, i_column_done, i_window_done} = done;
	end

	initial begin
		rst = 1'b1;
		i_start = 1'b0;
		{i_save_done, i_weight_done, i_vector_done, i_column_done, i_window_done} = '0;
		cycle_limit = timeout_cycles();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_reset_idle();
		test_full_run();
		test_layer_order();
		test_channels();
		test_backpressure();
		$display("errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
		if (value_errs + proto_errs == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
